//--- pmu_pkg.sv
package pmu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CSR port widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned csr_addr_w = 12;
    // Also the width of the timeouts and inactivity counters
    localparam int unsigned csr_data_w = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [csr_addr_w-1:0] pmu_enable_addr    = 12'hF00;
    localparam logic [csr_addr_w-1:0] pmu_config_addr    = 12'hF01;
    localparam logic [csr_addr_w-1:0] idle_timeout_addr  = 12'hF02;
    localparam logic [csr_addr_w-1:0] sleep_timeout_addr = 12'hF03;
    // Read-only, current power state
    localparam logic [csr_addr_w-1:0] pmu_status_addr    = 12'hF04;

    // Timeout reset values, in clock cycles
    localparam logic [csr_data_w-1:0] idle_timeout_rst  = 32'd1000;
    localparam logic [csr_data_w-1:0] sleep_timeout_rst = 32'd10000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Config register layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned cfg_w = 4;

    // Gate the clock on core idle alone
    localparam int unsigned cfg_aggressive_bit   = 0;
    localparam int unsigned cfg_cache_gating_bit = 1;
    // Deep state is retention when set, off when clear
    localparam int unsigned cfg_retention_bit    = 2;
    localparam int unsigned cfg_power_gating_bit = 3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Power states, also the status register value
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        pwr_active      = 2'd0,
        pwr_clock_gated = 2'd1,
        pwr_retention   = 2'd2,
        pwr_off         = 2'd3
    } power_state_e;

endpackage

//--- pmu_csr.sv
`timescale 1ns/1ps

module pmu_csr (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    // CSR access port
    input  logic                           csr_access_i,
    input  logic [pmu_pkg::csr_addr_w-1:0] csr_addr_i,
    input  logic                           csr_write_i,
    input  logic [pmu_pkg::csr_data_w-1:0] csr_wdata_i,
    output logic [pmu_pkg::csr_data_w-1:0] csr_rdata_o,

    // Current state for the status register
    input  pmu_pkg::power_state_e          state_i,

    // Configuration to the controller and timers
    output logic                           pm_enable_o,
    output logic                           aggressive_gating_o,
    output logic                           cache_gating_en_o,
    output logic                           retention_mode_o,
    output logic                           power_gating_en_o,
    output logic [pmu_pkg::csr_data_w-1:0] idle_timeout_o,
    output logic [pmu_pkg::csr_data_w-1:0] sleep_timeout_o
);

    import pmu_pkg::*;

    logic                  pm_enable_q;
    logic [cfg_w-1:0]      cfg_q;
    logic [csr_data_w-1:0] idle_timeout_q;
    logic [csr_data_w-1:0] sleep_timeout_q;
    logic                  csr_wr;

    assign csr_wr = csr_access_i & csr_write_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pm_enable_q     <= 1'b0;
            cfg_q           <= '0;
            idle_timeout_q  <= idle_timeout_rst;
            sleep_timeout_q <= sleep_timeout_rst;
        end else if (csr_wr) begin
            case (csr_addr_i)
                pmu_enable_addr:
                    pm_enable_q <= csr_wdata_i[0];
                pmu_config_addr:
                    cfg_q <= csr_wdata_i[cfg_w-1:0];
                idle_timeout_addr:
                    idle_timeout_q <= csr_wdata_i;
                sleep_timeout_addr:
                    sleep_timeout_q <= csr_wdata_i;
                // Status and unmapped addresses drop the write
                default: ;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        csr_rdata_o = '0;
        if (csr_access_i) begin
            case (csr_addr_i)
                pmu_enable_addr:
                    csr_rdata_o = csr_data_w'(pm_enable_q);
                pmu_config_addr:
                    csr_rdata_o = csr_data_w'(cfg_q);
                idle_timeout_addr:
                    csr_rdata_o = idle_timeout_q;
                sleep_timeout_addr:
                    csr_rdata_o = sleep_timeout_q;
                pmu_status_addr:
                    csr_rdata_o = csr_data_w'(state_i);
                default:
                    csr_rdata_o = '0;
            endcase
        end
    end

    // Config fields split out by bit position
    assign pm_enable_o         = pm_enable_q;
    assign aggressive_gating_o = cfg_q[cfg_aggressive_bit];
    assign cache_gating_en_o   = cfg_q[cfg_cache_gating_bit];
    assign retention_mode_o    = cfg_q[cfg_retention_bit];
    assign power_gating_en_o   = cfg_q[cfg_power_gating_bit];
    assign idle_timeout_o      = idle_timeout_q;
    assign sleep_timeout_o     = sleep_timeout_q;

    // Status register is read-only, a write there changes nothing
    a_status_wr_ignored: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (csr_wr && (csr_addr_i == pmu_status_addr))
            |=> $stable({pm_enable_q, cfg_q, idle_timeout_q, sleep_timeout_q})
    ) else $error("pmu_csr: write to status address modified a register");

endmodule

//--- activity_timer.sv
`timescale 1ns/1ps

module activity_timer (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    // Activity of the watched block
    input  logic                           busy_i,

    // Thresholds in clock cycles
    input  logic [pmu_pkg::csr_data_w-1:0] idle_timeout_i,
    input  logic [pmu_pkg::csr_data_w-1:0] sleep_timeout_i,

    // Verdicts
    output logic                           idle_o,
    output logic                           sleep_o
);

    import pmu_pkg::*;

    // Consecutive inactive cycles
    logic [csr_data_w-1:0] count_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Saturating inactivity counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (busy_i) begin
            count_q <= '0;
        end else if (count_q != '1) begin
            count_q <= count_q + csr_data_w'(1);
        end
    end

    // Threshold compares, straight off the counter register
    assign idle_o  = (count_q >= idle_timeout_i);
    assign sleep_o = (count_q >= sleep_timeout_i);

    // Any busy cycle restarts the count
    a_busy_clears: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        busy_i |=> (count_q == '0)
    ) else $error("activity_timer: counter not cleared after busy");

    // With ordered thresholds the sleep verdict never leads idle
    a_sleep_implies_idle: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (sleep_timeout_i >= idle_timeout_i) |-> (!sleep_o || idle_o)
    ) else $error("activity_timer: sleep_o without idle_o");

endmodule

//--- power_state_ctrl.sv
`timescale 1ns/1ps

module power_state_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Configuration from the CSR block
    input  logic                  pm_enable_i,
    input  logic                  aggressive_gating_i,
    input  logic                  cache_gating_en_i,
    input  logic                  retention_mode_i,
    input  logic                  power_gating_en_i,

    // Raw activity, used for immediate wake
    input  logic                  core_busy_i,
    input  logic                  cache_busy_i,

    // Timer verdicts
    input  logic                  core_idle_i,
    input  logic                  core_sleep_i,
    input  logic                  cache_idle_i,
    input  logic                  cache_sleep_i,

    // State and power controls
    output pmu_pkg::power_state_e state_o,
    output logic                  clk_gate_o,
    output logic                  cache_gate_o,
    output logic                  retention_o,
    output logic                  power_off_o
);

    import pmu_pkg::*;

    power_state_e state_q;
    power_state_e state_d;
    logic         wake;
    logic         deep_ok;
    logic         gate_ok;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Any activity or a disabled unit forces active
    assign wake    = core_busy_i | cache_busy_i | ~pm_enable_i;
    assign deep_ok = core_sleep_i & cache_sleep_i & power_gating_en_i;
    // Non-aggressive mode waits for the cache as well
    assign gate_ok = core_idle_i & (aggressive_gating_i | cache_idle_i);

    // No dependence on the current state, deeper states are entered directly
    always_comb begin
        state_d = pwr_active;
        if (wake) begin
            state_d = pwr_active;
        end else if (deep_ok) begin
            if (retention_mode_i) begin
                state_d = pwr_retention;
            end else begin
                state_d = pwr_off;
            end
        end else if (gate_ok) begin
            state_d = pwr_clock_gated;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= pwr_active;
        end else begin
            state_q <= state_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        clk_gate_o  = 1'b0;
        retention_o = 1'b0;
        power_off_o = 1'b0;
        case (state_q)
            pwr_clock_gated: begin
                clk_gate_o = 1'b1;
            end
            pwr_retention: begin
                clk_gate_o  = 1'b1;
                retention_o = 1'b1;
            end
            pwr_off: begin
                clk_gate_o  = 1'b1;
                power_off_o = 1'b1;
            end
            default: ;
        endcase
    end

    // Cache follows the core clock gate only when allowed
    assign cache_gate_o = clk_gate_o & cache_gating_en_i;

    assign state_o = state_q;

    // Retention and power-off are exclusive deep states
    a_deep_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(retention_o && power_off_o)
    ) else $error("power_state_ctrl: retention and power-off both high");

endmodule

//--- pmu_top.sv
`timescale 1ns/1ps

module pmu_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    // CSR access port
    input  logic                           csr_access_i,
    input  logic [pmu_pkg::csr_addr_w-1:0] csr_addr_i,
    input  logic                           csr_write_i,
    input  logic [pmu_pkg::csr_data_w-1:0] csr_wdata_i,
    output logic [pmu_pkg::csr_data_w-1:0] csr_rdata_o,

    // Activity from the core and its cache
    input  logic                           core_busy_i,
    input  logic                           cache_busy_i,

    // Power controls
    output logic                           clk_gate_o,
    output logic                           cache_gate_o,
    output logic                           retention_o,
    output logic                           power_off_o
);

    import pmu_pkg::*;

    logic                  pm_enable;
    logic                  aggressive_gating;
    logic                  cache_gating_en;
    logic                  retention_mode;
    logic                  power_gating_en;
    logic [csr_data_w-1:0] idle_timeout;
    logic [csr_data_w-1:0] sleep_timeout;
    logic                  core_idle;
    logic                  core_sleep;
    logic                  cache_idle;
    logic                  cache_sleep;
    power_state_e          state;

    pmu_csr i_pmu_csr (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .csr_access_i        (csr_access_i),
        .csr_addr_i          (csr_addr_i),
        .csr_write_i         (csr_write_i),
        .csr_wdata_i         (csr_wdata_i),
        .csr_rdata_o         (csr_rdata_o),
        .state_i             (state),
        .pm_enable_o         (pm_enable),
        .aggressive_gating_o (aggressive_gating),
        .cache_gating_en_o   (cache_gating_en),
        .retention_mode_o    (retention_mode),
        .power_gating_en_o   (power_gating_en),
        .idle_timeout_o      (idle_timeout),
        .sleep_timeout_o     (sleep_timeout)
    );

    // One monitor per block, same thresholds
    activity_timer i_core_timer (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .busy_i          (core_busy_i),
        .idle_timeout_i  (idle_timeout),
        .sleep_timeout_i (sleep_timeout),
        .idle_o          (core_idle),
        .sleep_o         (core_sleep)
    );

    activity_timer i_cache_timer (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .busy_i          (cache_busy_i),
        .idle_timeout_i  (idle_timeout),
        .sleep_timeout_i (sleep_timeout),
        .idle_o          (cache_idle),
        .sleep_o         (cache_sleep)
    );

    power_state_ctrl i_power_state_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .pm_enable_i         (pm_enable),
        .aggressive_gating_i (aggressive_gating),
        .cache_gating_en_i   (cache_gating_en),
        .retention_mode_i    (retention_mode),
        .power_gating_en_i   (power_gating_en),
        .core_busy_i         (core_busy_i),
        .cache_busy_i        (cache_busy_i),
        .core_idle_i         (core_idle),
        .core_sleep_i        (core_sleep),
        .cache_idle_i        (cache_idle),
        .cache_sleep_i       (cache_sleep),
        .state_o             (state),
        .clk_gate_o          (clk_gate_o),
        .cache_gate_o        (cache_gate_o),
        .retention_o         (retention_o),
        .power_off_o         (power_off_o)
    );

endmodule

//--- tb_pmu_top.sv
`timescale 1ns/1ps

module tb_pmu_top;

    import pmu_pkg::*;

    localparam int unsigned clk_period      = 8;
    localparam int unsigned directed_cycles = 300;
    localparam int unsigned rand_cycles     = 800;
    localparam int unsigned watchdog_ns     = 2 * (directed_cycles + rand_cycles) * clk_period;
    localparam logic [31:0] small_idle      = 32'd5;
    localparam logic [31:0] small_sleep     = 32'd20;

    logic                  clk;
    logic                  rst_n;
    logic                  csr_access;
    logic [csr_addr_w-1:0] csr_addr;
    logic                  csr_write;
    logic [csr_data_w-1:0] csr_wdata;
    logic [csr_data_w-1:0] csr_rdata;
    logic                  core_busy;
    logic                  cache_busy;
    logic                  clk_gate;
    logic                  cache_gate;
    logic                  retention;
    logic                  power_off;
    logic [3:0]            outs;

    // Reference model state
    logic                  m_enable;
    logic [cfg_w-1:0]      m_cfg;
    logic [csr_data_w-1:0] m_idle_to;
    logic [csr_data_w-1:0] m_sleep_to;
    logic [csr_data_w-1:0] m_core_cnt;
    logic [csr_data_w-1:0] m_cache_cnt;
    power_state_e          m_state;

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned tests_passed = 0;
    int unsigned tests_failed = 0;
    int unsigned test_start_errors = 0;

    pmu_top i_pmu_top (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .csr_access_i (csr_access),
        .csr_addr_i   (csr_addr),
        .csr_write_i  (csr_write),
        .csr_wdata_i  (csr_wdata),
        .csr_rdata_o  (csr_rdata),
        .core_busy_i  (core_busy),
        .cache_busy_i (cache_busy),
        .clk_gate_o   (clk_gate),
        .cache_gate_o (cache_gate),
        .retention_o  (retention),
        .power_off_o  (power_off)
    );

    assign outs = {clk_gate, cache_gate, retention, power_off};

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the run did not complete", watchdog_ns);
        $display("Some tests failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [csr_data_w-1:0] next_count(
        input logic [csr_data_w-1:0] cnt,
        input logic                  busy
    );
        if (busy) begin
            return '0;
        end
        return (cnt == '1) ? cnt : cnt + 1;
    endfunction

    function automatic power_state_e next_state(input logic c_busy, input logic k_busy);
        logic core_idle;
        logic core_sleep;
        logic cache_idle;
        logic cache_sleep;
        core_idle   = (m_core_cnt >= m_idle_to);
        core_sleep  = (m_core_cnt >= m_sleep_to);
        cache_idle  = (m_cache_cnt >= m_idle_to);
        cache_sleep = (m_cache_cnt >= m_sleep_to);
        if (c_busy || k_busy || !m_enable) begin
            return pwr_active;
        end
        if (core_sleep && cache_sleep && m_cfg[cfg_power_gating_bit]) begin
            return m_cfg[cfg_retention_bit] ? pwr_retention : pwr_off;
        end
        if (core_idle && (m_cfg[cfg_aggressive_bit] || cache_idle)) begin
            return pwr_clock_gated;
        end
        return pwr_active;
    endfunction

    // Compare pre-edge outputs, then step the model with this edge's inputs
    always @(posedge clk) begin
        logic [3:0] exp_outs;
        if (!rst_n) begin
            m_enable    = 1'b0;
            m_cfg       = '0;
            m_idle_to   = idle_timeout_rst;
            m_sleep_to  = sleep_timeout_rst;
            m_core_cnt  = '0;
            m_cache_cnt = '0;
            m_state     = pwr_active;
        end else begin
            exp_outs = {m_state != pwr_active,
                        (m_state != pwr_active) && m_cfg[cfg_cache_gating_bit],
                        m_state == pwr_retention, m_state == pwr_off};
            checks++;
            if (outs !== exp_outs) begin
                errors++;
                $display("CHECK FAILED {clk_gate_o,cache_gate_o,retention_o,power_off_o}: %s",
                         $sformatf("got 0x%h expected 0x%h at %0t", outs, exp_outs, $time));
            end
            m_state     = next_state(core_busy, cache_busy);
            m_core_cnt  = next_count(m_core_cnt, core_busy);
            m_cache_cnt = next_count(m_cache_cnt, cache_busy);
            if (csr_access && csr_write) begin
                case (csr_addr)
                    pmu_enable_addr:    m_enable = csr_wdata[0];
                    pmu_config_addr:    m_cfg = csr_wdata[cfg_w-1:0];
                    idle_timeout_addr:  m_idle_to = csr_wdata;
                    sleep_timeout_addr: m_sleep_to = csr_wdata;
                    default: ;
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic csr_wr(input logic [csr_addr_w-1:0] addr, input logic [csr_data_w-1:0] data);
        @(negedge clk);
        csr_access = 1'b1;
        csr_write  = 1'b1;
        csr_addr   = addr;
        csr_wdata  = data;
        @(negedge clk);
        csr_access = 1'b0;
        csr_write  = 1'b0;
    endtask

    // Sampled mid low phase, read data and model both settled
    task automatic csr_rd_check(input logic [csr_addr_w-1:0] addr,
                                input logic [csr_data_w-1:0] exp, input bit use_model);
        @(negedge clk);
        csr_access = 1'b1;
        csr_write  = 1'b0;
        csr_addr   = addr;
        #2;
        check_value($sformatf("csr_rdata_o at 0x%h", addr), csr_rdata,
                    use_model ? csr_data_w'(m_state) : exp);
        @(negedge clk);
        csr_access = 1'b0;
    endtask

    // Edges until any output in the mask rises
    task automatic edges_until_high(input logic [3:0] mask, input string name, output int edges);
        edges = 0;
        while (((outs & mask) == 4'd0) && edges < 200) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if ((outs & mask) == 4'd0) begin
            errors++;
            $display("%s never went high within 200 cycles", name);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    task automatic pulse_busy();
        @(negedge clk);
        core_busy  = 1'b1;
        cache_busy = 1'b1;
        @(negedge clk);
        core_busy  = 1'b0;
        cache_busy = 1'b0;
    endtask

    task automatic drive_random_busy(input int unsigned cycles);
        int core_left;
        int cache_left;
        core_left  = 0;
        cache_left = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (core_left == 0) begin
                core_busy = ($urandom % 4) == 0;
                core_left = core_busy ? 1 + $urandom % 3 : $urandom % 30;
            end else begin
                core_left--;
            end
            if (cache_left == 0) begin
                cache_busy = ($urandom % 4) == 0;
                cache_left = cache_busy ? 1 + $urandom % 3 : $urandom % 30;
            end else begin
                cache_left--;
            end
        end
    endtask

    task automatic random_csr_traffic(input int unsigned ops);
        logic [31:0] idle;
        repeat (ops) begin
            repeat ($urandom % 12) @(negedge clk);
            idle = 1 + ($urandom % 8);
            case ($urandom % 4)
                0: csr_wr(pmu_config_addr, $urandom % 16);
                1: begin
                    csr_wr(idle_timeout_addr, idle);
                    csr_wr(sleep_timeout_addr, idle + ($urandom % 16));
                end
                2: csr_wr(pmu_enable_addr, {31'd0, ($urandom % 6) != 0});
                default: csr_rd_check(pmu_status_addr, '0, 1'b1);
            endcase
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int edges;
        void'($urandom(32'h1575_5961));
        rst_n      = 1'b0;
        csr_access = 1'b0;
        csr_addr   = '0;
        csr_write  = 1'b0;
        csr_wdata  = '0;
        core_busy  = 1'b0;
        cache_busy = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        csr_rd_check(pmu_enable_addr, 32'd0, 1'b0);
        csr_rd_check(pmu_config_addr, 32'd0, 1'b0);
        csr_rd_check(idle_timeout_addr, idle_timeout_rst, 1'b0);
        csr_rd_check(sleep_timeout_addr, sleep_timeout_rst, 1'b0);
        csr_rd_check(pmu_status_addr, csr_data_w'(pwr_active), 1'b0);
        csr_wr(pmu_enable_addr, 32'd1);
        csr_wr(pmu_config_addr, 32'hA);
        csr_wr(idle_timeout_addr, 32'h0000_1234);
        csr_wr(sleep_timeout_addr, 32'h0000_5678);
        csr_wr(pmu_status_addr, 32'h3);
        csr_wr(12'h123, 32'hDEAD_BEEF);
        csr_rd_check(pmu_enable_addr, 32'd1, 1'b0);
        csr_rd_check(pmu_config_addr, 32'hA, 1'b0);
        csr_rd_check(idle_timeout_addr, 32'h0000_1234, 1'b0);
        csr_rd_check(sleep_timeout_addr, 32'h0000_5678, 1'b0);
        csr_rd_check(pmu_status_addr, csr_data_w'(pwr_active), 1'b0);
        csr_rd_check(12'h123, 32'd0, 1'b0);
        end_test("reset and register access");

        csr_wr(pmu_config_addr, 32'h1);
        csr_wr(idle_timeout_addr, small_idle);
        csr_wr(sleep_timeout_addr, small_sleep);
        pulse_busy();
        edges_until_high(4'b1000, "clk_gate_o", edges);
        check_value("clk_gate_o rise delay", edges, small_idle + 1);
        @(negedge clk);
        core_busy = 1'b1;
        @(posedge clk);
        #1;
        check_value("clk_gate_o after wake", 32'(clk_gate), 32'd0);
        end_test("clock gating");

        // Core idles long while the cache stays busy
        csr_wr(pmu_config_addr, 32'h2);
        @(negedge clk);
        core_busy  = 1'b0;
        cache_busy = 1'b1;
        repeat (10) @(negedge clk);
        cache_busy = 1'b0;
        edges_until_high(4'b1000, "clk_gate_o", edges);
        check_value("clk_gate_o rise delay", edges, small_idle + 1);
        check_value("cache_gate_o", 32'(cache_gate), 32'd1);
        csr_wr(pmu_config_addr, 32'h0);
        check_value("cache_gate_o", 32'(cache_gate), 32'd0);
        check_value("clk_gate_o", 32'(clk_gate), 32'd1);
        end_test("non-aggressive mode");

        csr_wr(pmu_config_addr, 32'hE);
        pulse_busy();
        edges_until_high(4'b0011, "retention_o", edges);
        check_value("retention_o rise delay", edges, small_sleep + 1);
        check_value("power_off_o", 32'(power_off), 32'd0);
        csr_rd_check(pmu_status_addr, csr_data_w'(pwr_retention), 1'b0);
        csr_wr(pmu_config_addr, 32'hA);
        pulse_busy();
        edges_until_high(4'b0011, "power_off_o", edges);
        check_value("power_off_o rise delay", edges, small_sleep + 1);
        check_value("retention_o", 32'(retention), 32'd0);
        csr_rd_check(pmu_status_addr, csr_data_w'(pwr_off), 1'b0);
        end_test("deep states");

        fork
            drive_random_busy(rand_cycles);
            random_csr_traffic(rand_cycles / 20);
        join
        end_test("random run");

        $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- pmu_top.f
pmu_pkg.sv
pmu_csr.sv
activity_timer.sv
power_state_ctrl.sv
pmu_top.sv
tb_pmu_top.sv

//--- Makefile
TOP := tb_pmu_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module pmu_top -f pmu_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f pmu_top.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
